// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module axi_shared_memory_tb -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
+incdir+verilog
verilog/axi_ic_pkg.sv
verilog/grant_fsm.sv
verilog/beat_counter.sv
verilog/port_mux.sv
verilog/axi_memory.sv
verilog/axi_shared_memory.sv
test/axi_shared_memory_tb.sv

// ==== test/axi_shared_memory_tb.sv ====
`include "axi_ic_config.svh"

module axi_shared_memory_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import axi_ic_pkg::*;

    localparam int NREQ      = `AXI_IC_NUM_REQ;
    localparam int BYTES     = `AXI_IC_DATA_W / 8;
    localparam int NUM_TESTS = 16;

    typedef enum int {OP_WR, OP_RD, OP_RD2, OP_WRRD} op_e;

    // req2 and addr2 are used by the paired operations only
    typedef struct {
        string       name;
        int          req;
        op_e         op;
        logic [31:0] addr;
        int          len;
        logic [31:0] dseed;
        logic [3:0]  strb;
        bit          bp;
        int          req2;
        logic [31:0] addr2;
    } test_t;

    test_t tests [NUM_TESTS] = '{
        '{"wr_single_r1",    1, OP_WR,   32'h010, 1, 32'h1111_0000, 4'hF, 1'b0, 0, 32'h0},
        '{"rd_single_r1",    1, OP_RD,   32'h010, 1, 32'h0,         4'hF, 1'b0, 0, 32'h0},
        '{"wr_single_r2",    2, OP_WR,   32'h024, 1, 32'h2222_0000, 4'hF, 1'b0, 0, 32'h0},
        '{"rd_single_r2",    2, OP_RD,   32'h024, 1, 32'h0,         4'hF, 1'b0, 0, 32'h0},
        '{"wr_single_r3",    3, OP_WR,   32'h038, 1, 32'h3333_0000, 4'hF, 1'b0, 0, 32'h0},
        '{"rd_single_r3",    3, OP_RD,   32'h038, 1, 32'h0,         4'hF, 1'b0, 0, 32'h0},
        '{"wr_burst_full",   2, OP_WR,   32'h100, 4, 32'h0F0F_0F0F, 4'hF, 1'b0, 0, 32'h0},
        '{"wr_burst_strb",   2, OP_WR,   32'h100, 4, 32'hA5A5_5A5A, 4'h6, 1'b0, 0, 32'h0},
        '{"rd_burst",        2, OP_RD,   32'h100, 4, 32'h0,         4'hF, 1'b0, 0, 32'h0},
        '{"wr_area_a",       1, OP_WR,   32'h200, 4, 32'hAAAA_0000, 4'hF, 1'b0, 0, 32'h0},
        '{"wr_area_b",       3, OP_WR,   32'h280, 4, 32'hBBBB_0000, 4'hF, 1'b0, 0, 32'h0},
        '{"rd_sim_r1_r3",    1, OP_RD2,  32'h200, 4, 32'h0,         4'hF, 1'b0, 3, 32'h280},
        '{"wr_long",         3, OP_WR,   32'h300, 8, 32'h7777_0000, 4'hF, 1'b0, 0, 32'h0},
        '{"rd_backpressure", 1, OP_RD,   32'h300, 8, 32'h0,         4'hF, 1'b1, 0, 32'h0},
        '{"wr_rd_parallel",  2, OP_WRRD, 32'h380, 4, 32'hCCCC_0000, 4'hF, 1'b0, 1, 32'h100},
        '{"rd_parallel_wr",  3, OP_RD,   32'h380, 4, 32'h0,         4'hF, 1'b0, 0, 32'h0}
    };

    logic      CLK;
    logic      RST;
    axi_addr_t aw [NREQ];
    axi_w_t    w  [NREQ];
    axi_b_t    b  [NREQ];
    axi_addr_t ar [NREQ];
    axi_r_t    r  [NREQ];
    grant_t    aw_ready;
    grant_t    w_ready;
    grant_t    ar_ready;
    grant_t    b_ready;
    grant_t    r_ready;

    logic [`AXI_IC_DATA_W-1:0] ref_mem [`AXI_IC_MEM_WORDS];

    int    seed;
    int    errors;
    int    tests_run;
    int    tests_bad;
    int    cycles;
    int    limit;
    int    rd_own;
    int    wr_own;
    string cur_name;

    axi_shared_memory dut_i (
        .CLK      (CLK),
        .RST      (RST),
        .aw       (aw),
        .w        (w),
        .b        (b),
        .ar       (ar),
        .r        (r),
        .aw_ready (aw_ready),
        .w_ready  (w_ready),
        .ar_ready (ar_ready),
        .b_ready  (b_ready),
        .r_ready  (r_ready)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_name, what, exp, act);
            errors++;
        end
    endtask

    function automatic int first_set(input grant_t v);
        for (int i = 0; i < NREQ; i++) begin
            if (v[i]) begin
                return i + 1;
            end
        end
        return 0;
    endfunction

    task automatic do_write(input int q, input logic [31:0] addr, input int len,
                            input logic [31:0] dseed, input logic [3:0] strb);
        int          p;
        int          idx;
        logic [31:0] data;
        p = q - 1;
        aw[p] = '{valid: 1'b1, addr: addr, len: 8'(len - 1), size: 3'd2, burst: 2'b01};
        do @(negedge CLK); while (!aw_ready[p]);
        @(posedge CLK);
        #2;
        aw[p].valid = 1'b0;
        for (int i = 0; i < len; i++) begin
            data = $random(seed) ^ dseed;
            w[p] = '{valid: 1'b1, data: data, strb: strb, last: (i == len - 1)};
            do @(negedge CLK); while (!w_ready[p]);
            @(posedge CLK);
            #2;
            idx = ((addr >> 2) + i) % `AXI_IC_MEM_WORDS;
            for (int k = 0; k < BYTES; k++) begin
                if (strb[k]) begin
                    ref_mem[idx][8*k +: 8] = data[8*k +: 8];
                end
            end
        end
        w[p] = '0;
        b_ready[p] = 1'b1;
        do @(negedge CLK); while (!b[p].valid);
        check_value("bresp", RESP_OKAY, b[p].resp);
        @(posedge CLK);
        #2;
        b_ready[p] = 1'b0;
    endtask

    task automatic do_read(input int q, input logic [31:0] addr, input int len, input bit bp);
        int p;
        int beat;
        int idx;
        p = q - 1;
        beat = 0;
        ar[p] = '{valid: 1'b1, addr: addr, len: 8'(len - 1), size: 3'd2, burst: 2'b01};
        do @(negedge CLK); while (!ar_ready[p]);
        @(posedge CLK);
        #2;
        ar[p].valid = 1'b0;
        while (beat < len) begin
            r_ready[p] = bp ? 1'($random(seed)) : 1'b1;
            @(negedge CLK);
            if (r[p].valid && r_ready[p]) begin
                idx = ((addr >> 2) + beat) % `AXI_IC_MEM_WORDS;
                check_value($sformatf("req%0d beat %0d data", q, beat), ref_mem[idx], r[p].data);
                check_value($sformatf("req%0d beat %0d resp", q, beat), RESP_OKAY, r[p].resp);
                check_value($sformatf("req%0d beat %0d last", q, beat), (beat == len - 1),
                            r[p].last);
                beat++;
            end
            @(posedge CLK);
            #2;
        end
        r_ready[p] = 1'b0;
    endtask

    // Expected owners by fixed priority, held until the transaction ends
    always @(negedge CLK) begin
        grant_t rv;
        grant_t wv;
        int     rc;
        int     wc;
        if (RST) begin
            rd_own = 0;
            wr_own = 0;
        end else begin
            for (int i = 0; i < NREQ; i++) begin
                rv[i] = ar[i].valid;
                wv[i] = aw[i].valid;
            end
            rc = (rd_own != 0) ? rd_own : first_set(rv);
            wc = (wr_own != 0) ? wr_own : first_set(wv);
            for (int i = 0; i < NREQ; i++) begin
                if (rc != i + 1) begin
                    check_value($sformatf("req%0d {ar_ready,rvalid,rdata} not granted", i + 1),
                                32'd0, {ar_ready[i], r[i].valid, |r[i].data});
                end
                if (wc != i + 1) begin
                    check_value($sformatf("req%0d {aw_ready,w_ready,bvalid} not granted", i + 1),
                                32'd0, {aw_ready[i], w_ready[i], b[i].valid});
                end
            end
            rd_own = rc;
            if (rc != 0) begin
                if (r[rc-1].valid && r[rc-1].last && r_ready[rc-1]) begin
                    rd_own = 0;
                end
            end
            wr_own = wc;
            if (wc != 0) begin
                if (b[wc-1].valid && b_ready[wc-1]) begin
                    wr_own = 0;
                end
            end
        end
    end

    always @(posedge CLK) begin
        if (!RST) begin
            cycles++;
        end
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", limit);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int fails_before;
        int maxlen;
        seed      = 32'h5548;
        errors    = 0;
        tests_run = 0;
        tests_bad = 0;
        cycles    = 0;
        RST       = 1'b1;
        b_ready   = '0;
        r_ready   = '0;
        for (int i = 0; i < NREQ; i++) begin
            aw[i] = '0;
            w[i]  = '0;
            ar[i] = '0;
        end
        maxlen = 0;
        foreach (tests[t]) begin
            if (tests[t].len > maxlen) begin
                maxlen = tests[t].len;
            end
        end
        limit = 40 * NUM_TESTS + maxlen * NUM_TESTS;

        repeat (5) @(posedge CLK);
        #2;
        RST = 1'b0;
        repeat (2) @(posedge CLK);
        #2;

        foreach (tests[t]) begin
            cur_name     = tests[t].name;
            fails_before = errors;
            case (tests[t].op)
                OP_WR: begin
                    do_write(tests[t].req, tests[t].addr, tests[t].len, tests[t].dseed,
                             tests[t].strb);
                end
                OP_RD: begin
                    do_read(tests[t].req, tests[t].addr, tests[t].len, tests[t].bp);
                end
                OP_RD2: begin
                    fork
                        do_read(tests[t].req, tests[t].addr, tests[t].len, tests[t].bp);
                        do_read(tests[t].req2, tests[t].addr2, tests[t].len, tests[t].bp);
                    join
                end
                default: begin
                    fork
                        do_write(tests[t].req, tests[t].addr, tests[t].len, tests[t].dseed,
                                 tests[t].strb);
                        do_read(tests[t].req2, tests[t].addr2, tests[t].len, tests[t].bp);
                    join
                end
            endcase
            tests_run++;
            if (errors != fails_before) begin
                tests_bad++;
            end
            $display("%-18s %s", cur_name, (errors == fails_before) ? "passed" : "had errors");
            repeat (2) @(posedge CLK);
            #2;
        end

        $display("Tests: %0d run, %0d with errors, %0d failed checks",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog/axi_ic_config.svh ====
`ifndef AXI_IC_CONFIG_SVH
`define AXI_IC_CONFIG_SVH

// Bus widths
`define AXI_IC_ADDR_W 32
`define AXI_IC_DATA_W 32

// Memory depth in words
`define AXI_IC_MEM_WORDS 256

// Requesters sharing the memory port
`define AXI_IC_NUM_REQ 3

`endif

// ==== verilog/axi_ic_pkg.sv ====
`include "axi_ic_config.svh"

package axi_ic_pkg;

    // Address channel request, used for both AW and AR
    typedef struct packed {
        logic                      valid;
        logic [`AXI_IC_ADDR_W-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
    } axi_addr_t;

    // Write data beat
    typedef struct packed {
        logic                        valid;
        logic [`AXI_IC_DATA_W-1:0]   data;
        logic [`AXI_IC_DATA_W/8-1:0] strb;
        logic                        last;
    } axi_w_t;

    // Write response
    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axi_b_t;

    // Read data beat
    typedef struct packed {
        logic                      valid;
        logic [`AXI_IC_DATA_W-1:0] data;
        logic [1:0]                resp;
        logic                      last;
    } axi_r_t;

    // One bit per requester, requester 1 at bit 0
    typedef logic [`AXI_IC_NUM_REQ-1:0] grant_t;

    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// ==== verilog/axi_memory.sv ====
`include "axi_ic_config.svh"

module axi_memory (
    input  logic                  CLK,
    input  logic                  RST,
    input  axi_ic_pkg::axi_addr_t aw,
    input  axi_ic_pkg::axi_addr_t ar,
    input  axi_ic_pkg::axi_w_t    w,
    input  logic                  b_ready,
    input  logic                  r_ready,
    output logic                  aw_ready,
    output logic                  w_ready,
    output logic                  ar_ready,
    output axi_ic_pkg::axi_b_t    b,
    output axi_ic_pkg::axi_r_t    r
);
    import axi_ic_pkg::*;

    localparam int BYTES = `AXI_IC_DATA_W / 8;
    localparam int OFS_W = $clog2(BYTES);
    localparam int IDX_W = $clog2(`AXI_IC_MEM_WORDS);

    logic [`AXI_IC_DATA_W-1:0] mem [`AXI_IC_MEM_WORDS];

    logic                      wr_active;
    logic [IDX_W-1:0]          wr_idx;
    logic                      b_valid;
    logic                      aw_fire;
    logic                      w_fire;

    logic [IDX_W-1:0]          rd_idx;
    logic [`AXI_IC_DATA_W-1:0] rd_data;
    logic                      rd_busy;
    logic                      rd_last;
    logic                      ar_fire;
    logic                      r_fire;

    // Write side, a new AW waits until the previous response is taken
    assign aw_ready = !wr_active && !b_valid;
    assign w_ready  = wr_active;
    assign aw_fire  = aw.valid && aw_ready;
    assign w_fire   = w.valid && w_ready;

    always_ff @(posedge CLK) begin
        if (RST) begin
            wr_active <= 1'b0;
            b_valid   <= 1'b0;
        end else begin
            if (aw_fire) begin
                wr_active <= 1'b1;
            end else if (w_fire && w.last) begin
                wr_active <= 1'b0;
                b_valid   <= 1'b1;
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    // INCR only, one word per beat
    always_ff @(posedge CLK) begin
        if (aw_fire) begin
            wr_idx <= aw.addr[OFS_W +: IDX_W];
        end else if (w_fire) begin
            wr_idx <= wr_idx + 1'b1;
            for (int i = 0; i < BYTES; i++) begin
                if (w.strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    // Read side, the counter's busy flag doubles as RVALID
    assign ar_ready = !rd_busy;
    assign ar_fire  = ar.valid && ar_ready;
    assign r_fire   = rd_busy && r_ready;

    beat_counter rd_cnt_i (
        .CLK  (CLK),
        .RST  (RST),
        .load (ar_fire),
        .len  (ar.len),
        .step (r_fire),
        .last (rd_last),
        .busy (rd_busy)
    );

    // Next word fetched only when the current beat is taken
    always_ff @(posedge CLK) begin
        if (ar_fire) begin
            rd_data <= mem[ar.addr[OFS_W +: IDX_W]];
            rd_idx  <= ar.addr[OFS_W +: IDX_W] + 1'b1;
        end else if (r_fire && !rd_last) begin
            rd_data <= mem[rd_idx];
            rd_idx  <= rd_idx + 1'b1;
        end
    end

    assign b = '{valid: b_valid, resp: RESP_OKAY};
    assign r = '{valid: rd_busy, data: rd_data, resp: RESP_OKAY, last: rd_last};

endmodule

// ==== verilog/axi_shared_memory.sv ====
`include "axi_ic_config.svh"

module axi_shared_memory (
    input  logic                  CLK,
    input  logic                  RST,
    input  axi_ic_pkg::axi_addr_t aw [`AXI_IC_NUM_REQ],
    input  axi_ic_pkg::axi_w_t    w  [`AXI_IC_NUM_REQ],
    output axi_ic_pkg::axi_b_t    b  [`AXI_IC_NUM_REQ],
    input  axi_ic_pkg::axi_addr_t ar [`AXI_IC_NUM_REQ],
    output axi_ic_pkg::axi_r_t    r  [`AXI_IC_NUM_REQ],
    output axi_ic_pkg::grant_t    aw_ready,
    output axi_ic_pkg::grant_t    w_ready,
    output axi_ic_pkg::grant_t    ar_ready,
    input  axi_ic_pkg::grant_t    b_ready,
    input  axi_ic_pkg::grant_t    r_ready
);
    import axi_ic_pkg::*;

    grant_t    w_req;
    grant_t    r_req;
    grant_t    w_grant;
    grant_t    r_grant;
    logic      w_done;
    logic      r_done;
    logic      w_last;

    axi_addr_t mem_aw;
    axi_addr_t mem_ar;
    axi_w_t    mem_w;
    axi_b_t    mem_b;
    axi_r_t    mem_r;
    logic      mem_aw_ready;
    logic      mem_w_ready;
    logic      mem_ar_ready;
    logic      mem_b_ready;
    logic      mem_r_ready;

    for (genvar i = 0; i < `AXI_IC_NUM_REQ; i++) begin : g_req
        assign w_req[i] = aw[i].valid;
        assign r_req[i] = ar[i].valid;
    end

    // Read ends on the accepted last beat, write on the accepted response
    assign r_done = mem_r.valid && mem_r.last && mem_r_ready;
    assign w_done = mem_b.valid && mem_b_ready;

    grant_fsm w_grant_i (
        .CLK   (CLK),
        .RST   (RST),
        .req   (w_req),
        .done  (w_done),
        .grant (w_grant)
    );

    grant_fsm r_grant_i (
        .CLK   (CLK),
        .RST   (RST),
        .req   (r_req),
        .done  (r_done),
        .grant (r_grant)
    );

    beat_counter wr_cnt_i (
        .CLK  (CLK),
        .RST  (RST),
        .load (mem_aw.valid && mem_aw_ready),
        .len  (mem_aw.len),
        .step (mem_w.valid && mem_w_ready),
        .last (w_last),
        .busy ()
    );

    port_mux mux_i (
        .req_aw       (aw),
        .req_ar       (ar),
        .req_w        (w),
        .req_b_ready  (b_ready),
        .req_r_ready  (r_ready),
        .w_grant      (w_grant),
        .r_grant      (r_grant),
        .mem_aw       (mem_aw),
        .mem_ar       (mem_ar),
        .mem_w        (mem_w),
        .mem_b_ready  (mem_b_ready),
        .mem_r_ready  (mem_r_ready),
        .mem_aw_ready (mem_aw_ready),
        .mem_w_ready  (mem_w_ready),
        .mem_ar_ready (mem_ar_ready),
        .mem_b        (mem_b),
        .mem_r        (mem_r),
        .w_last       (w_last),
        .req_aw_ready (aw_ready),
        .req_w_ready  (w_ready),
        .req_ar_ready (ar_ready),
        .req_b        (b),
        .req_r        (r)
    );

    axi_memory mem_i (
        .CLK      (CLK),
        .RST      (RST),
        .aw       (mem_aw),
        .ar       (mem_ar),
        .w        (mem_w),
        .b_ready  (mem_b_ready),
        .r_ready  (mem_r_ready),
        .aw_ready (mem_aw_ready),
        .w_ready  (mem_w_ready),
        .ar_ready (mem_ar_ready),
        .b        (mem_b),
        .r        (mem_r)
    );

endmodule

// ==== verilog/beat_counter.sv ====
module beat_counter (
    input  logic       CLK,
    input  logic       RST,
    input  logic       load,
    input  logic [7:0] len,
    input  logic       step,
    output logic       last,
    output logic       busy
);

    // Beats left after the current one
    logic [7:0] remain;

    assign last = busy && (remain == 8'd0);

    always_ff @(posedge CLK) begin
        if (RST) begin
            busy   <= 1'b0;
            remain <= 8'd0;
        end else if (load) begin
            busy   <= 1'b1;
            remain <= len;
        end else if (step) begin
            if (remain == 8'd0) begin
                busy <= 1'b0;
            end else begin
                remain <= remain - 8'd1;
            end
        end
    end

    // A beat outside a burst means the handshake and the count disagree
    a_step_in_burst: assert property (
        @(posedge CLK) disable iff (RST)
        step |-> busy
    ) else $error("beat_counter: step while no burst is loaded");

endmodule

// ==== verilog/grant_fsm.sv ====
module grant_fsm (
    input  logic               CLK,
    input  logic               RST,
    input  axi_ic_pkg::grant_t req,
    input  logic               done,
    output axi_ic_pkg::grant_t grant
);
    import axi_ic_pkg::*;

    // Zero while idle, otherwise the requester holding the channel
    grant_t owner;
    grant_t pick;
    logic   idle;

    assign idle = (owner == '0);

    // Lowest set bit wins, so requester 1 beats 2 beats 3
    assign pick = req & (~req + 1'b1);

    // Grant shows up in the idle cycle already
    assign grant = idle ? pick : owner;

    always_ff @(posedge CLK) begin
        if (RST) begin
            owner <= '0;
        end else if (idle) begin
            owner <= pick;
        end else if (done) begin
            owner <= '0;
        end
    end

    a_grant_onehot: assert property (
        @(posedge CLK) disable iff (RST)
        $onehot0(grant)
    ) else $error("grant_fsm: grant %b is not one-hot", grant);

    // Grant must not move mid-transaction
    a_grant_hold: assert property (
        @(posedge CLK) disable iff (RST)
        (!idle && !done) |=> (grant == $past(grant))
    ) else $error("grant_fsm: grant changed from %b to %b", $past(grant), grant);

endmodule

// ==== verilog/port_mux.sv ====
`include "axi_ic_config.svh"

module port_mux (
    input  axi_ic_pkg::axi_addr_t req_aw [`AXI_IC_NUM_REQ],
    input  axi_ic_pkg::axi_addr_t req_ar [`AXI_IC_NUM_REQ],
    input  axi_ic_pkg::axi_w_t    req_w  [`AXI_IC_NUM_REQ],
    input  axi_ic_pkg::grant_t    req_b_ready,
    input  axi_ic_pkg::grant_t    req_r_ready,
    input  axi_ic_pkg::grant_t    w_grant,
    input  axi_ic_pkg::grant_t    r_grant,
    output axi_ic_pkg::axi_addr_t mem_aw,
    output axi_ic_pkg::axi_addr_t mem_ar,
    output axi_ic_pkg::axi_w_t    mem_w,
    output logic                  mem_b_ready,
    output logic                  mem_r_ready,
    input  logic                  mem_aw_ready,
    input  logic                  mem_w_ready,
    input  logic                  mem_ar_ready,
    input  axi_ic_pkg::axi_b_t    mem_b,
    input  axi_ic_pkg::axi_r_t    mem_r,
    input  logic                  w_last,
    output axi_ic_pkg::grant_t    req_aw_ready,
    output axi_ic_pkg::grant_t    req_w_ready,
    output axi_ic_pkg::grant_t    req_ar_ready,
    output axi_ic_pkg::axi_b_t    req_b  [`AXI_IC_NUM_REQ],
    output axi_ic_pkg::axi_r_t    req_r  [`AXI_IC_NUM_REQ]
);

    // Request side toward the memory, zero when nobody holds a grant
    always_comb begin
        mem_aw = '0;
        mem_w  = '0;
        mem_ar = '0;
        for (int i = 0; i < `AXI_IC_NUM_REQ; i++) begin
            if (w_grant[i]) begin
                mem_aw = req_aw[i];
                mem_w  = req_w[i];
            end
            if (r_grant[i]) begin
                mem_ar = req_ar[i];
            end
        end
        // WLAST from the beat count
        mem_w.last = w_last;
    end

    assign mem_b_ready = |(w_grant & req_b_ready);
    assign mem_r_ready = |(r_grant & req_r_ready);

    assign req_aw_ready = w_grant & {`AXI_IC_NUM_REQ{mem_aw_ready}};
    assign req_w_ready  = w_grant & {`AXI_IC_NUM_REQ{mem_w_ready}};
    assign req_ar_ready = r_grant & {`AXI_IC_NUM_REQ{mem_ar_ready}};

    // Responses go back to the owner only
    always_comb begin
        for (int i = 0; i < `AXI_IC_NUM_REQ; i++) begin
            req_b[i] = '0;
            req_r[i] = '0;
            if (w_grant[i]) begin
                req_b[i] = mem_b;
            end
            if (r_grant[i]) begin
                req_r[i] = mem_r;
            end
        end
    end

    // Requester's own WLAST must not come ahead of the beat count
    always_comb begin
        for (int i = 0; i < `AXI_IC_NUM_REQ; i++) begin
            if (w_grant[i] && req_w[i].valid && mem_w_ready && req_w[i].last) begin
                assert (w_last)
                    else $error("port_mux: requester %0d WLAST ahead of the beat count",
                                i + 1);
            end
        end
    end

endmodule
